//--- verilog.f
+incdir+design
design/rvCorePkg.sv
design/rvDecoder.sv
design/rvExecute.sv
design/rvRegFile.sv
design/rvSequencer.sv
design/rvPcCounter.sv
design/rvCoreTop.sv
sim/rvCoreTb.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - design
    files:
      - design/rvCorePkg.sv
      - design/rvDecoder.sv
      - design/rvExecute.sv
      - design/rvRegFile.sv
      - design/rvSequencer.sv
      - design/rvPcCounter.sv
      - design/rvCoreTop.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/rvCoreTb.sv

//--- sim/rvCoreTb.sv
// RV32I core testbench
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module rvCoreTb;

    localparam int progLen   = 200;
    localparam int idleLimit = 50;     // Cycles allowed between retires
    localparam int runLimit  = 20000;  // Cycles allowed for the whole program
    localparam logic [31:0] lastPc = `RV_RESET_PC + 4 * (progLen - 1);

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] data;
    } expRetire_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        imemReq;
    logic [31:0] imemAddr;
    logic        imemValid = 1'b0;
    logic [31:0] imemData = '0;
    logic        dmemReq;
    logic [31:0] dmemAddr;
    logic        dmemWrite;
    logic [31:0] dmemWdata;
    logic [3:0]  dmemStrb;
    logic        dmemValid = 1'b0;
    logic [31:0] dmemRdata = '0;
    logic        retireValid;
    logic [31:0] retirePc;
    logic [4:0]  retireRd;
    logic [31:0] retireRdData;
    logic [31:0] instrCount;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] refMem [256];              // Model copy of the data array
    logic [31:0] refRegs [`RV_NUM_REGS];
    logic [31:0] refPc = `RV_RESET_PC;
    logic [31:0] lfsr = 32'h0000_567e;
    int          errors = 0;
    int          retired = 0;
    logic        done = 1'b0;

    logic        iBusy = 1'b0;
    int          iWait;
    logic [31:0] iAddr;
    logic        dBusy = 1'b0;
    int          dWait;
    logic [31:0] dAddr;

    rvCoreTop dut0 (
        .clk          (clk),
        .reset        (reset),
        .imemReq      (imemReq),
        .imemAddr     (imemAddr),
        .imemValid    (imemValid),
        .imemData     (imemData),
        .dmemReq      (dmemReq),
        .dmemAddr     (dmemAddr),
        .dmemWrite    (dmemWrite),
        .dmemWdata    (dmemWdata),
        .dmemStrb     (dmemStrb),
        .dmemValid    (dmemValid),
        .dmemRdata    (dmemRdata),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .retireRd     (retireRd),
        .retireRdData (retireRdData),
        .instrCount   (instrCount)
    );

    always #4 clk = ~clk;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic compareValue(input string what, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    // Data array offset aligned to the access size
    function automatic logic [31:0] memOffset(input logic [1:0] size);
        logic [31:0] w;
        logic [31:0] b;
        w = randBits(8);
        b = '0;
        if (size != 2'd2)
            b = randBits(2);
        case (size)
            2'd0:    return {22'b0, w[7:0], b[1:0]};
            2'd1:    return {22'b0, w[7:0], b[1], 1'b0};
            default: return {22'b0, w[7:0], 2'b00};
        endcase
    endfunction

    task automatic genProgram();
        logic [31:0] r;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          skip;
        for (int i = 0; i < progLen - 1; i++) begin
            r = randBits(5);
            rd = r[4:0];
            r = randBits(5);
            rs1 = r[4:0];
            r = randBits(5);
            rs2 = r[4:0];
            r = randBits(3);
            f3 = r[2:0];
            r = randBits(1);
            skip = 1 + int'(r[0]);  // Forward only
            if (i + skip > progLen - 1)
                skip = progLen - 1 - i;
            r = randBits(4);
            case (r[3:0])
                4'd0: begin
                    r = randBits(20);
                    imem[i] = {r[19:0], rd, `RV_OP_LUI};
                end
                4'd1: begin
                    r = randBits(20);
                    imem[i] = {r[19:0], rd, `RV_OP_AUIPC};
                end
                4'd2: begin
                    imm = 4 * skip;
                    imem[i] = {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
                end
                4'd3: begin
                    r = randBits(1);
                    imm = 4 * (i + skip) + int'(r[0]);  // Bit 0 set at times
                    imem[i] = {imm[11:0], 5'd0, 3'b000, rd, `RV_OP_JALR};
                end
                4'd4, 4'd5: begin
                    if (f3 == 3'd2 || f3 == 3'd3)
                        f3 = f3 + 3'd4;
                    imm = 4 * skip;
                    imem[i] = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                               `RV_OP_BRANCH};
                end
                4'd6, 4'd7: begin
                    if (f3 == 3'd3 || f3 >= 3'd6)
                        f3 = 3'd2;
                    imm = memOffset(f3[1:0]);
                    imem[i] = {imm[11:0], 5'd0, f3, rd, `RV_OP_LOAD};
                end
                4'd8, 4'd9: begin
                    f3 = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
                    imm = memOffset(f3[1:0]);
                    imem[i] = {imm[11:5], rs2, 5'd0, f3, imm[4:0], `RV_OP_STORE};
                end
                4'd10, 4'd11, 4'd12: begin
                    r = randBits(12);
                    imm = {20'b0, r[11:0]};
                    if (f3 == 3'd1)
                        imm[11:5] = 7'd0;
                    if (f3 == 3'd5)
                        imm[11:5] = {1'b0, r[10], 5'b0};  // SRLI or SRAI
                    imem[i] = {imm[11:0], rs1, f3, rd, `RV_OP_OPIMM};
                end
                default: begin
                    r = randBits(1);
                    f7 = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[0], 5'b0} : 7'd0;
                    imem[i] = {f7, rs2, rs1, f3, rd, `RV_OP_OP};
                end
            endcase
        end
        imem[progLen - 1] = {20'b0, 5'd0, `RV_OP_JAL};  // Jump to itself
    endtask

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
        logic signed [31:0] sx;
        sx = x;
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101: begin
                if (alt)
                    return sx >>> y[4:0];
                return x >> y[4:0];
            end
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] x,
                                       input logic [31:0] y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            3'b111:  return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // Instruction-set model stepping one instruction per call
    function automatic expRetire_t refStep();
        expRetire_t  e;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [31:0] immS;
        logic [31:0] immB;
        logic [31:0] immU;
        logic [31:0] immJ;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] res;
        logic [31:0] npc;
        logic        wr;
        int          nBytes;
        int          lane;
        ins  = imem[refPc[9:2]];
        a    = refRegs[ins[19:15]];
        b    = refRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immU = {ins[31:12], 12'h000};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        wr   = 1'b1;
        res  = '0;
        npc  = refPc + 32'd4;
        case (ins[6:0])
            `RV_OP_LUI:   res = immU;
            `RV_OP_AUIPC: res = refPc + immU;
            `RV_OP_JAL: begin
                res = refPc + 32'd4;
                npc = refPc + immJ;
            end
            `RV_OP_JALR: begin
                res = refPc + 32'd4;
                npc = (a + immI) & 32'hffff_fffe;
            end
            `RV_OP_BRANCH: begin
                wr = 1'b0;
                if (branchRef(ins[14:12], a, b))
                    npc = refPc + immB;
            end
            `RV_OP_LOAD: begin
                addr = a + immI;
                word = refMem[addr[9:2]] >> {addr[1:0], 3'b000};
                case (ins[14:12])
                    3'b000:  res = {{24{word[7]}}, word[7:0]};
                    3'b001:  res = {{16{word[15]}}, word[15:0]};
                    3'b100:  res = {24'b0, word[7:0]};
                    3'b101:  res = {16'b0, word[15:0]};
                    default: res = word;
                endcase
            end
            `RV_OP_STORE: begin
                wr = 1'b0;
                addr = a + immS;
                word = refMem[addr[9:2]];
                nBytes = 1 << ins[13:12];
                for (int k = 0; k < nBytes; k++) begin
                    lane = int'(addr[1:0]) + k;
                    word[8 * lane +: 8] = b[8 * k +: 8];
                end
                refMem[addr[9:2]] = word;
            end
            `RV_OP_OPIMM: res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
            `RV_OP_OP:    res = aluRef(ins[14:12], ins[30], a, b);
            default:      wr = 1'b0;
        endcase
        e.pc   = refPc;
        e.rd   = wr ? ins[11:7] : 5'd0;
        e.data = res;
        if (wr && ins[11:7] != 5'd0)
            refRegs[ins[11:7]] = res;  // x0 never written
        refPc = npc;
        return e;
    endfunction

    // Instruction memory
    always @(posedge clk) begin
        imemValid <= 1'b0;
        if (reset) begin
            iBusy <= 1'b0;
        end else if (iBusy) begin
            if (iWait == 0) begin
                imemValid <= 1'b1;
                imemData  <= imem[iAddr[9:2]];
                iBusy     <= 1'b0;
            end else begin
                iWait <= iWait - 1;
            end
        end else if (imemReq) begin
            iBusy <= 1'b1;
            iWait <= randBits(2);
            iAddr <= imemAddr;
        end
    end

    // Data memory where writes land when the request is seen
    always @(posedge clk) begin
        dmemValid <= 1'b0;
        if (reset) begin
            dBusy <= 1'b0;
        end else if (dBusy) begin
            if (dWait == 0) begin
                dmemValid <= 1'b1;
                dmemRdata <= dmem[dAddr[9:2]];
                dBusy     <= 1'b0;
            end else begin
                dWait <= dWait - 1;
            end
        end else if (dmemReq) begin
            dBusy <= 1'b1;
            dWait <= randBits(2);
            dAddr <= dmemAddr;
            for (int k = 0; k < 4; k++) begin
                if (dmemWrite && dmemStrb[k])
                    dmem[dmemAddr[9:2]][8 * k +: 8] <= dmemWdata[8 * k +: 8];
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && (imemReq || dmemReq) && (iBusy || dBusy || (imemReq && dmemReq))) begin
            errors++;
            $display("Memory request issued while an earlier request was still unanswered");
        end
    end

    // Compare each retire with the model
    always @(negedge clk) begin
        expRetire_t expRet;
        if (!reset && retireValid && !done) begin
            expRet = refStep();
            compareValue($sformatf("retire %0d pc", retired), expRet.pc, retirePc);
            compareValue($sformatf("retire %0d rd", retired), {27'b0, expRet.rd},
                         {27'b0, retireRd});
            if (expRet.rd != 5'd0)
                compareValue($sformatf("retire %0d data", retired), expRet.data, retireRdData);
            retired++;
            if (expRet.pc == lastPc)
                done = 1'b1;
        end
    end

    initial begin
        int cycles;
        int idle;
        cycles = 0;
        idle   = 0;
        for (int w = 0; w < 256; w++) begin
            dmem[w]   = randBits(32);
            refMem[w] = dmem[w];
        end
        for (int r = 0; r < `RV_NUM_REGS; r++)
            refRegs[r] = '0;
        genProgram();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        while (!done && cycles < runLimit && idle < idleLimit) begin
            @(negedge clk);
            cycles++;
            idle = retireValid ? 0 : idle + 1;
        end
        if (!done) begin
            errors++;
            if (idle >= idleLimit)
                $display("Timeout: no instruction retired within %0d cycles", idleLimit);
            else
                $display("Timeout: program did not finish within %0d cycles", runLimit);
        end else begin
            @(negedge clk);  // Count updates at the end of WB
            compareValue("instruction count", retired, instrCount);
            for (int w = 0; w < 256; w++)
                compareValue($sformatf("data word %0d", w), refMem[w], dmem[w]);
        end
        $display("Errors: %0d, retired instructions: %0d", errors, retired);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- design/rvCoreTop.sv
// RV32I multi-cycle core
`timescale 1ns/10ps

module rvCoreTop (
    input  logic        clk,
    input  logic        reset,
    output logic        imemReq,
    output logic [31:0] imemAddr,
    input  logic        imemValid,
    input  logic [31:0] imemData,
    output logic        dmemReq,
    output logic [31:0] dmemAddr,
    output logic        dmemWrite,
    output logic [31:0] dmemWdata,
    output logic [3:0]  dmemStrb,
    input  logic        dmemValid,
    input  logic [31:0] dmemRdata,
    output logic        retireValid,
    output logic [31:0] retirePc,
    output logic [4:0]  retireRd,
    output logic [31:0] retireRdData,
    output logic [31:0] instrCount
);
    import rvCorePkg::*;

    ctrl_t       ctrl;
    logic [31:0] instrReg;
    logic [31:0] loadDataReg;
    logic [31:0] pc;
    logic [31:0] nextPc;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] wbData;
    logic        rfWe;
    logic        pcAdvance;
    logic        branchTaken;

    rvDecoder uDecoder (
        .instr (instrReg),
        .ctrl  (ctrl)
    );

    rvExecute uExecute (
        .instr       (instrReg),
        .ctrl        (ctrl),
        .pc          (pc),
        .rs1Data     (rs1Data),
        .rs2Data     (rs2Data),
        .loadData    (loadDataReg),
        .memAddr     (dmemAddr),
        .storeData   (dmemWdata),
        .storeStrb   (dmemStrb),
        .branchTaken (branchTaken),
        .nextPc      (nextPc),
        .wbData      (wbData)
    );

    rvRegFile uRegFile (
        .clk     (clk),
        .reset   (reset),
        .rs1Addr (instrReg[19:15]),
        .rs2Addr (instrReg[24:20]),
        .rdAddr  (instrReg[11:7]),
        .we      (rfWe),
        .wdata   (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    rvSequencer uSequencer (
        .clk         (clk),
        .reset       (reset),
        .imemValid   (imemValid),
        .imemData    (imemData),
        .dmemValid   (dmemValid),
        .dmemRdata   (dmemRdata),
        .ctrl        (ctrl),
        .imemReq     (imemReq),
        .instrReg    (instrReg),
        .dmemReq     (dmemReq),
        .loadDataReg (loadDataReg),
        .rfWe        (rfWe),
        .pcAdvance   (pcAdvance),
        .retireValid (retireValid)
    );

    rvPcCounter uPcCounter (
        .clk         (clk),
        .reset       (reset),
        .pcAdvance   (pcAdvance),
        .branchTaken (branchTaken),
        .nextPc      (nextPc),
        .pc          (pc),
        .instrCount  (instrCount)
    );

    assign imemAddr     = pc;
    assign dmemWrite    = ctrl.memWrite;
    assign retirePc     = pc;
    assign retireRd     = ctrl.regWrite ? instrReg[11:7] : 5'd0;  // Zero when nothing written
    assign retireRdData = wbData;

endmodule

//--- design/rvPcCounter.sv
// Program counter and retire count
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module rvPcCounter (
    input  logic        clk,
    input  logic        reset,
    input  logic        pcAdvance,
    input  logic        branchTaken,
    input  logic [31:0] nextPc,
    output logic [31:0] pc,
    output logic [31:0] instrCount
);
    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= `RV_RESET_PC;
            instrCount <= '0;
        end else if (pcAdvance) begin
            pc         <= nextPc;
            instrCount <= instrCount + 32'd1;  // One per retired instruction
        end
    end

    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

    // B offsets are only half-word aligned, so a taken target is checked too
    assert property (@(posedge clk) disable iff (reset)
        (pcAdvance && branchTaken) |-> nextPc[1:0] == 2'b00);

endmodule

//--- design/rvSequencer.sv
// Multi-cycle instruction sequencer
`timescale 1ns/10ps

module rvSequencer (
    input  logic             clk,
    input  logic             reset,
    input  logic             imemValid,
    input  logic [31:0]      imemData,
    input  logic             dmemValid,
    input  logic [31:0]      dmemRdata,
    input  rvCorePkg::ctrl_t ctrl,
    output logic             imemReq,
    output logic [31:0]      instrReg,
    output logic             dmemReq,
    output logic [31:0]      loadDataReg,
    output logic             rfWe,
    output logic             pcAdvance,
    output logic             retireValid
);
    import rvCorePkg::*;

    seqState_e state;
    logic      kickFetch;  // Requests the first fetch after reset

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FETCH;
            imemReq   <= 1'b0;
            dmemReq   <= 1'b0;
            kickFetch <= 1'b1;
            instrReg  <= '0;  // Decodes to no memory or register activity
        end else begin
            case (state)
                FETCH: begin
                    imemReq   <= kickFetch;
                    kickFetch <= 1'b0;
                    if (imemValid) begin
                        instrReg <= imemData;
                        state    <= DECODE;
                    end
                end
                DECODE: state <= EXEC;
                EXEC: begin
                    if (ctrl.memRead || ctrl.memWrite) begin
                        dmemReq <= 1'b1;
                        state   <= MEM;
                    end else begin
                        state <= WB;
                    end
                end
                MEM: begin
                    dmemReq <= 1'b0;
                    if (dmemValid)
                        state <= WB;
                end
                WB: begin
                    imemReq <= 1'b1;  // Next fetch in FETCH's first cycle
                    state   <= FETCH;
                end
                default: state <= FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MEM && dmemValid)
            loadDataReg <= dmemRdata;
    end

    // Register write, PC update and retire share the WB cycle
    assign retireValid = (state == WB);
    assign pcAdvance   = (state == WB);
    assign rfWe        = (state == WB) && ctrl.regWrite;

    assert property (@(posedge clk) disable iff (reset) !(imemReq && dmemReq));

    // Loads and stores retire only after their data answer
    assert property (@(posedge clk) disable iff (reset)
        (retireValid && (ctrl.memRead || ctrl.memWrite)) |-> $past(dmemValid));

endmodule

//--- design/rvRegFile.sv
// RV32I integer register file
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module rvRegFile (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1Addr,
    input  logic [4:0]  rs2Addr,
    input  logic [4:0]  rdAddr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);
    logic [31:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we && rdAddr != 5'd0) begin  // x0 stays zero
            regs[rdAddr] <= wdata;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    // x0 reads as zero only because every write to it is dropped
    assert property (@(posedge clk) disable iff (reset) (rs1Addr == 5'd0) |-> (rs1Data == '0));

endmodule

//--- design/rvExecute.sv
// RV32I execute stage
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module rvExecute (
    input  logic [31:0]      instr,
    input  rvCorePkg::ctrl_t ctrl,
    input  logic [31:0]      pc,
    input  logic [31:0]      rs1Data,
    input  logic [31:0]      rs2Data,
    input  logic [31:0]      loadData,
    output logic [31:0]      memAddr,
    output logic [31:0]      storeData,
    output logic [3:0]       storeStrb,
    output logic             branchTaken,
    output logic [31:0]      nextPc,
    output logic [31:0]      wbData
);
    import rvCorePkg::*;

    logic [31:0] imm;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluResult;
    logic [31:0] pcPlus4;
    logic        cond;
    logic [1:0]  byteOff;
    logic [31:0] loadShifted;
    logic [31:0] loadExt;

    always_comb begin
        case (instr[6:0])
            `RV_OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            `RV_OP_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            `RV_OP_LUI,
            `RV_OP_AUIPC:  imm = {instr[31:12], 12'b0};
            `RV_OP_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            default:       imm = {{20{instr[31]}}, instr[31:20]};  // I-type
        endcase
    end

    assign opA     = ctrl.pcSrcA ? pc : rs1Data;
    assign opB     = ctrl.aluSrc ? imm : rs2Data;
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:   aluResult = opA + opB;
            ALU_SUB:   aluResult = opA - opB;
            ALU_SLL:   aluResult = opA << opB[4:0];
            ALU_SLT:   aluResult = {31'b0, $signed(opA) < $signed(opB)};
            ALU_SLTU:  aluResult = {31'b0, opA < opB};
            ALU_XOR:   aluResult = opA ^ opB;
            ALU_SRL:   aluResult = opA >> opB[4:0];
            ALU_SRA:   aluResult = $unsigned($signed(opA) >>> opB[4:0]);
            ALU_OR:    aluResult = opA | opB;
            ALU_AND:   aluResult = opA & opB;
            ALU_PASSB: aluResult = opB;
            default:   aluResult = '0;
        endcase
    end

    // Branch condition by func3
    always_comb begin
        case (instr[14:12])
            3'b000:  cond = rs1Data == rs2Data;
            3'b001:  cond = rs1Data != rs2Data;
            3'b100:  cond = $signed(rs1Data) < $signed(rs2Data);
            3'b101:  cond = $signed(rs1Data) >= $signed(rs2Data);
            3'b110:  cond = rs1Data < rs2Data;
            3'b111:  cond = rs1Data >= rs2Data;
            default: cond = 1'b0;
        endcase
    end

    assign branchTaken = ctrl.branch && cond;

    always_comb begin
        if (ctrl.jumpReg)
            nextPc = {aluResult[31:1], 1'b0};  // JALR target
        else if (branchTaken || ctrl.jump)
            nextPc = aluResult;                // PC+imm via pcSrcA
        else
            nextPc = pcPlus4;
    end

    // Store lanes
    assign memAddr   = aluResult;
    assign byteOff   = aluResult[1:0];
    assign storeData = rs2Data << {byteOff, 3'b000};

    always_comb begin
        case (ctrl.dataLen)
            2'b00:   storeStrb = 4'b0001 << byteOff;
            2'b01:   storeStrb = 4'b0011 << byteOff;
            default: storeStrb = 4'b1111;
        endcase
        if (!ctrl.memWrite)
            storeStrb = 4'b0000;
    end

    // Load extraction and extension
    assign loadShifted = loadData >> {byteOff, 3'b000};

    always_comb begin
        case (ctrl.dataLen)
            2'b00:   loadExt = {{24{ctrl.dataSign & loadShifted[7]}}, loadShifted[7:0]};
            2'b01:   loadExt = {{16{ctrl.dataSign & loadShifted[15]}}, loadShifted[15:0]};
            default: loadExt = loadShifted;
        endcase
    end

    always_comb begin
        case (ctrl.wbSel)
            WB_MEM:   wbData = loadExt;
            WB_PC4:   wbData = pcPlus4;
            WB_PCIMM: wbData = aluResult;  // AUIPC adds on the PC operand
            default:  wbData = aluResult;
        endcase
    end

endmodule

//--- design/rvDecoder.sv
// RV32I instruction decoder
`timescale 1ns/10ps
`include "rvCore_consts.svh"

module rvDecoder (
    input  logic [31:0]      instr,
    output rvCorePkg::ctrl_t ctrl
);
    import rvCorePkg::*;

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [1:0] memLen;
    aluOp_e     fnAluOp;  // From func3 and bit 30

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];

    // Word access coded as 3
    assign memLen = (func3[1:0] == 2'b10) ? 2'b11 : func3[1:0];

    always_comb begin
        case (func3)
            3'b000:  fnAluOp = (opcode == `RV_OP_OP && instr[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  fnAluOp = ALU_SLL;
            3'b010:  fnAluOp = ALU_SLT;
            3'b011:  fnAluOp = ALU_SLTU;
            3'b100:  fnAluOp = ALU_XOR;
            3'b101:  fnAluOp = instr[30] ? ALU_SRA : ALU_SRL;  // SRAI has bit 30 too
            3'b110:  fnAluOp = ALU_OR;
            default: fnAluOp = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl = '0;  // Unsupported opcodes do nothing
        case (opcode)
            `RV_OP_LOAD: begin
                ctrl.wbSel    = WB_MEM;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.dataLen  = memLen;
                ctrl.dataSign = ~func3[2];  // LBU and LHU zero-extend
            end
            `RV_OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.dataLen  = memLen;
            end
            `RV_OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.aluSrc = 1'b1;  // ALU forms the target
                ctrl.pcSrcA = 1'b1;
            end
            `RV_OP_JAL: begin
                ctrl.wbSel    = WB_PC4;
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.pcSrcA   = 1'b1;
            end
            `RV_OP_JALR: begin
                ctrl.wbSel    = WB_PC4;
                ctrl.jump     = 1'b1;
                ctrl.jumpReg  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            `RV_OP_OPIMM: begin
                ctrl.aluOp    = fnAluOp;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            `RV_OP_OP: begin
                ctrl.aluOp    = fnAluOp;
                ctrl.regWrite = 1'b1;
            end
            `RV_OP_LUI: begin
                ctrl.aluOp    = ALU_PASSB;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            `RV_OP_AUIPC: begin
                ctrl.wbSel    = WB_PCIMM;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.pcSrcA   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- design/rvCorePkg.sv
// RV32I core shared types
package rvCorePkg;

    // ALU operation codes
    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SUB   = 4'b0001,
        ALU_SLL   = 4'b0010,
        ALU_SLT   = 4'b0011,
        ALU_SLTU  = 4'b0100,
        ALU_XOR   = 4'b0101,
        ALU_SRL   = 4'b0110,
        ALU_SRA   = 4'b0111,
        ALU_OR    = 4'b1000,
        ALU_AND   = 4'b1001,
        ALU_PASSB = 4'b1010   // LUI
    } aluOp_e;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU   = 2'b00,
        WB_MEM   = 2'b01,  // Load data
        WB_PC4   = 2'b10,  // JAL, JALR link
        WB_PCIMM = 2'b11   // AUIPC
    } wbSel_e;

    typedef struct packed {
        wbSel_e     wbSel;
        logic       memWrite;
        logic       memRead;
        logic       branch;    // Conditional branches
        logic       jump;      // JAL and JALR
        logic       jumpReg;   // JALR only
        aluOp_e     aluOp;
        logic       regWrite;
        logic [1:0] dataLen;   // 0 byte, 1 half, 3 word
        logic       dataSign;
        logic       aluSrc;    // Immediate as operand B
        logic       pcSrcA;    // PC as operand A
    } ctrl_t;

    // Sequencer states
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        WB
    } seqState_e;

endpackage

//--- design/rvCore_consts.svh
// RV32I core constants
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Major opcodes in instr[6:0]
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_OPIMM   7'b0010011  // Register-immediate ALU ops
`define RV_OP_OP      7'b0110011  // Register-register ALU ops
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111

// First fetch address
`define RV_RESET_PC   32'h0000_0000

// Integer register count including x0
`define RV_NUM_REGS   32

`endif
